//--- dac_gen_pkg.sv
`default_nettype none

package dac_gen_pkg;

	// ============================================================
	// Sizes
	// ============================================================
	localparam int sample_width = 16;
	localparam int batch_size = 4;
	localparam int batch_width = sample_width * batch_size;
	localparam int fifo_depth = 4;
	localparam int fifo_addr_width = $clog2(fifo_depth);
	localparam int lane_width = $clog2(batch_size);

	// Triangle shape and LFSR feedback.
	localparam logic [sample_width-1:0] tri_step = 16'h0400;
	localparam int tri_half_period = 16;
	localparam int tri_phase_width = $clog2(2 * tri_half_period);
	localparam logic [sample_width-1:0] lfsr_taps = 16'hB400;

	// ============================================================
	// Types
	// ============================================================
	typedef logic [sample_width-1:0] sample_t;
	typedef logic [tri_phase_width-1:0] phase_t;
	typedef logic [fifo_addr_width-1:0] fifo_ptr_t;
	typedef logic [lane_width-1:0] lane_t;

	// Lane 0 sits in the low bits and goes out first.
	typedef sample_t [batch_size-1:0] batch_t;

	typedef struct packed {
		logic [batch_width-1:0] seed;
		logic clear;
		logic halt;
		logic load_seed;
		logic run_random;
		logic run_triangle;
	} cmd_t;

	typedef struct packed {
		logic random_active;
		logic triangle_active;
	} resp_t;

endpackage

`default_nettype wire

//--- lfsr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_bank (
	input logic clk,
	input logic reset,
	input logic rewind,
	input dac_gen_pkg::batch_t seed,
	input logic step,
	output dac_gen_pkg::batch_t batch
);

	dac_gen_pkg::batch_t lanes;

	// Galois form, shift right and fold in the taps on a one.
	function automatic dac_gen_pkg::sample_t lfsr_next(input dac_gen_pkg::sample_t value);
		dac_gen_pkg::sample_t shifted;
		shifted = value >> 1;
		if (value[0]) begin
			shifted = shifted ^ dac_gen_pkg::lfsr_taps;
		end
		return shifted;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
				lanes[i] <= dac_gen_pkg::sample_t'(1);
			end
		end else if (rewind) begin
			lanes <= seed;
		end else if (step) begin
			for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
				lanes[i] <= lfsr_next(lanes[i]);
			end
		end
	end

	// Current values form the batch.
	assign batch = lanes;

endmodule

`default_nettype wire

//--- triangle_wave_gen.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_wave_gen (
	input logic clk,
	input logic reset,
	input logic rewind,
	input logic step,
	output dac_gen_pkg::batch_t batch
);

	// Number of the next sample within one full period.
	dac_gen_pkg::phase_t phase;

	function automatic dac_gen_pkg::sample_t tri_value(input dac_gen_pkg::phase_t t);
		if (int'(t) < dac_gen_pkg::tri_half_period) begin
			return dac_gen_pkg::sample_t'(t) * dac_gen_pkg::tri_step;
		end
		return dac_gen_pkg::sample_t'(2 * dac_gen_pkg::tri_half_period - int'(t))
			* dac_gen_pkg::tri_step;
	endfunction

	// Full period is a power of two, so the counter wraps by itself.
	always_ff @(posedge clk) begin
		if (reset || rewind) begin
			phase <= '0;
		end else if (step) begin
			phase <= phase + dac_gen_pkg::phase_t'(dac_gen_pkg::batch_size);
		end
	end

	for (genvar i = 0; i < dac_gen_pkg::batch_size; i++) begin : g_lane
		assign batch[i] = tri_value(phase + dac_gen_pkg::phase_t'(i));
	end

endmodule

`default_nettype wire

//--- sample_generator.sv
`timescale 1ns/1ps
`default_nettype none

module sample_generator (
	input logic clk,
	input logic reset,
	input dac_gen_pkg::cmd_t cmd,
	input logic cmd_valid,
	input logic transfer_rdy,
	input logic full,
	output dac_gen_pkg::resp_t resp,
	output logic resp_valid,
	output logic push,
	output dac_gen_pkg::batch_t push_batch,
	output logic flush
);

	logic clear;
	logic rst;
	logic rewind;
	logic active;
	dac_gen_pkg::resp_t mode;
	dac_gen_pkg::batch_t seed_reg;
	dac_gen_pkg::batch_t seed_in;
	dac_gen_pkg::batch_t lfsr_batch;
	dac_gen_pkg::batch_t tri_batch;

	// ============================================================
	// Command decode
	// ============================================================
	assign clear = cmd_valid && cmd.clear;
	assign rst = reset || clear;
	assign flush = clear;
	assign rewind = cmd_valid && (cmd.halt || cmd.load_seed);

	// A zero lane would lock the LFSR up.
	always_comb begin
		seed_in = seed_reg;
		if (cmd_valid && cmd.load_seed) begin
			for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
				seed_in[i] = cmd.seed[i*dac_gen_pkg::sample_width +: dac_gen_pkg::sample_width];
				if (seed_in[i] == '0) begin
					seed_in[i] = dac_gen_pkg::sample_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= '0;
			for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
				seed_reg[i] <= dac_gen_pkg::sample_t'(1);
			end
		end else if (cmd_valid) begin
			if (cmd.halt) begin
				mode <= '0;
			end else begin
				// Random wins when both are asked for.
				mode.random_active <= cmd.run_random;
				mode.triangle_active <= cmd.run_triangle && !cmd.run_random;
			end
			if (cmd.load_seed) begin
				seed_reg <= seed_in;
			end
		end
	end

	// ============================================================
	// Sources and push
	// ============================================================
	assign active = mode.random_active || mode.triangle_active;
	assign push = active && !full;
	assign push_batch = mode.random_active ? lfsr_batch : tri_batch;

	lfsr_bank u_lfsr_bank (
		.clk(clk),
		.reset(rst),
		.rewind(rewind),
		.seed(seed_in),
		.step(push && mode.random_active),
		.batch(lfsr_batch)
	);

	triangle_wave_gen u_triangle_wave_gen (
		.clk(clk),
		.reset(rst),
		.rewind(rewind),
		.step(push && mode.triangle_active),
		.batch(tri_batch)
	);

	// Status goes out once per change, held until the processor can take it.
	always_ff @(posedge clk) begin
		if (reset) begin
			resp <= '0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			if (transfer_rdy && mode != resp) begin
				resp <= mode;
				resp_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- batch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module batch_fifo (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic push,
	input dac_gen_pkg::batch_t push_batch,
	input logic pop,
	output dac_gen_pkg::batch_t pop_batch,
	output logic full,
	output logic empty
);

	dac_gen_pkg::batch_t mem [dac_gen_pkg::fifo_depth];
	dac_gen_pkg::fifo_ptr_t wr_ptr;
	dac_gen_pkg::fifo_ptr_t rd_ptr;
	logic [dac_gen_pkg::fifo_addr_width:0] count;
	logic do_push;
	logic do_pop;

	assign full = (int'(count) == dac_gen_pkg::fifo_depth);
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head entry is visible without a read cycle.
	assign pop_batch = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_batch;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- dac_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module dac_serializer (
	input logic clk,
	input logic reset,
	input dac_gen_pkg::batch_t pop_batch,
	input logic empty,
	output logic pop,
	input logic dac_rdy,
	output logic [dac_gen_pkg::sample_width-1:0] dac_sample,
	output logic dac_valid
);

	dac_gen_pkg::batch_t held;
	dac_gen_pkg::lane_t lane;
	logic loaded;
	logic take;
	logic last;

	assign dac_valid = loaded;
	assign dac_sample = held[lane];
	assign take = dac_valid && dac_rdy;
	assign last = (lane == dac_gen_pkg::lane_t'(dac_gen_pkg::batch_size - 1));

	// Refill when idle, or right as the last lane leaves.
	assign pop = !empty && (!loaded || (take && last));

	always_ff @(posedge clk) begin
		if (pop) begin
			held <= pop_batch;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			loaded <= 1'b0;
			lane <= '0;
		end else if (pop) begin
			loaded <= 1'b1;
			lane <= '0;
		end else if (take) begin
			if (last) begin
				loaded <= 1'b0;
			end else begin
				lane <= lane + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- dac_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module dac_gen_top (
	input logic clk,
	input logic reset,
	input dac_gen_pkg::cmd_t cmd,
	input logic cmd_valid,
	input logic transfer_rdy,
	output dac_gen_pkg::resp_t resp,
	output logic resp_valid,
	input logic dac_rdy,
	output logic [dac_gen_pkg::sample_width-1:0] dac_sample,
	output logic dac_valid
);

	logic push;
	logic pop;
	logic flush;
	logic full;
	logic empty;
	dac_gen_pkg::batch_t push_batch;
	dac_gen_pkg::batch_t pop_batch;

	// ============================================================
	// Producer, buffer, consumer
	// ============================================================
	sample_generator u_sample_generator (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.transfer_rdy(transfer_rdy),
		.full(full),
		.resp(resp),
		.resp_valid(resp_valid),
		.push(push),
		.push_batch(push_batch),
		.flush(flush)
	);

	batch_fifo u_batch_fifo (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.push(push),
		.push_batch(push_batch),
		.pop(pop),
		.pop_batch(pop_batch),
		.full(full),
		.empty(empty)
	);

	dac_serializer u_dac_serializer (
		.clk(clk),
		.reset(reset),
		.pop_batch(pop_batch),
		.empty(empty),
		.pop(pop),
		.dac_rdy(dac_rdy),
		.dac_sample(dac_sample),
		.dac_valid(dac_valid)
	);

endmodule

`default_nettype wire

//--- dac_gen_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dac_gen_properties (
	input logic clk,
	input logic reset,
	input logic push,
	input logic full,
	input logic resp_valid,
	input logic dac_valid
);

	int failures = 0;

	assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else begin
			$error("push while the buffer is full");
			failures++;
		end

	assert property (@(posedge clk) disable iff (reset) resp_valid |=> !resp_valid)
		else begin
			$error("resp_valid high two cycles in a row");
			failures++;
		end

	assert property (@(posedge clk) reset |=> !dac_valid)
		else begin
			$error("dac_valid high right after reset");
			failures++;
		end

endmodule

bind dac_gen_top dac_gen_properties u_properties (
	.clk(clk),
	.reset(reset),
	.push(push),
	.full(full),
	.resp_valid(resp_valid),
	.dac_valid(dac_valid)
);

`default_nettype wire

//--- dac_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dac_gen_tb;

	logic clk;
	logic reset;
	dac_gen_pkg::cmd_t cmd;
	logic cmd_valid;
	logic transfer_rdy;
	dac_gen_pkg::resp_t resp;
	logic resp_valid;
	logic dac_rdy;
	logic [dac_gen_pkg::sample_width-1:0] dac_sample;
	logic dac_valid;

	// Reference model state.
	dac_gen_pkg::resp_t mode_now;
	logic src_random;
	int tri_n;
	dac_gen_pkg::sample_t seeds [dac_gen_pkg::batch_size];
	dac_gen_pkg::sample_t lfsr [dac_gen_pkg::batch_size];
	int exp_q[$];
	int got_q[$];
	int resp_q[$];

	dac_gen_top UUT (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.transfer_rdy(transfer_rdy),
		.resp(resp),
		.resp_valid(resp_valid),
		.dac_rdy(dac_rdy),
		.dac_sample(dac_sample),
		.dac_valid(dac_valid)
	);

	always #4 clk = ~clk;

	// Random stalls on both sides.
	always @(posedge clk) begin
		dac_rdy <= ($urandom % 4) != 0;
		transfer_rdy <= ($urandom % 4) != 0;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input int got, input int expected, input string what);
		if (got != expected) begin
			report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, expected));
		end
	endtask

	// ============================================================
	// Reference model
	// ============================================================
	task automatic rewind_model();
		exp_q.delete();
		tri_n = 0;
		lfsr = seeds;
	endtask

	task automatic predict_batch();
		int t;
		for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
			if (src_random) begin
				exp_q.push_back(int'(lfsr[i]));
				lfsr[i] = (lfsr[i] >> 1) ^ (lfsr[i][0] ? dac_gen_pkg::lfsr_taps : 16'h0000);
			end else begin
				t = tri_n % (2 * dac_gen_pkg::tri_half_period);
				if (t >= dac_gen_pkg::tri_half_period) begin
					t = 2 * dac_gen_pkg::tri_half_period - t;
				end
				exp_q.push_back((t * int'(dac_gen_pkg::tri_step)) & 'hFFFF);
				tri_n++;
			end
		end
	endtask

	// One clock edge, checking the DAC transfer if one took place.
	task automatic sample_edge();
		@(posedge clk);
		if (dac_valid && dac_rdy) begin
			if (exp_q.size() == 0) begin
				predict_batch();
			end
			got_q.push_back(int'(dac_sample));
			check_value(int'(dac_sample), exp_q.pop_front(), "DAC sample");
		end
	endtask

	// Drain mode stops after eight idle cycles.
	task automatic collect_samples(input int count, input logic drain);
		int idle;
		int waited;
		idle = 0;
		waited = 0;
		got_q.delete();
		while (drain ? (idle < 8) : (got_q.size() < count)) begin
			sample_edge();
			waited++;
			if (waited > 200 + 8 * count) begin
				report_failure("Timeout while waiting for DAC samples");
			end
			idle = dac_valid ? 0 : idle + 1;
		end
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			check_value(int'(dac_valid), 0, "dac_valid while idle");
		end
	endtask

	task automatic wait_responses();
		int waited;
		waited = 0;
		while (resp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 50) begin
				report_failure("Timeout while waiting for a status response");
			end
		end
	endtask

	task automatic send_command(input logic [71:0] word, input int count);
		dac_gen_pkg::cmd_t c;
		dac_gen_pkg::resp_t next;
		c = word[68:0];
		next.random_active = c.run_random;
		next.triangle_active = c.run_triangle && !c.run_random;
		if (c.halt || c.clear) begin
			next = '0;
		end
		if (next != mode_now) begin
			resp_q.push_back(int'(next));
		end
		mode_now = next;
		sample_edge();
		cmd <= c;
		cmd_valid <= 1'b1;
		if (c.load_seed) begin
			for (int i = 0; i < dac_gen_pkg::batch_size; i++) begin
				seeds[i] = c.seed[i*dac_gen_pkg::sample_width +: dac_gen_pkg::sample_width];
				if (seeds[i] == 16'h0000) begin
					seeds[i] = 16'h0001;
				end
			end
			rewind_model();
		end
		if (c.run_random || c.run_triangle) begin
			src_random = c.run_random;
		end
		sample_edge();
		cmd_valid <= 1'b0;
		if (c.halt || c.clear) begin
			collect_samples(0, 1'b1);
			expect_quiet(16);
			if (c.clear) begin
				seeds = '{default: 16'h0001};
			end
			rewind_model();
		end else begin
			collect_samples(count, 1'b0);
		end
	endtask

	// One response per change of mode, in order.
	always @(posedge clk) begin
		if (!reset && resp_valid) begin
			if (resp_q.size() == 0) begin
				report_failure("Response seen without a change of mode");
			end else begin
				check_value(int'(resp), resp_q.pop_front(), "response status");
			end
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int fd;
		int n;
		int count;
		logic [7:0] tag;
		logic [71:0] word;
		logic [8*160-1:0] line;
		void'($urandom(99279));
		clk = 1'b0;
		reset = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		dac_rdy = 1'b0;
		transfer_rdy = 1'b0;
		mode_now = '0;
		src_random = 1'b0;
		seeds = '{default: 16'h0001};
		rewind_model();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		expect_quiet(20);
		fd = $fopen("dac_gen_input.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open dac_gen_input.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				count = 0;
				n = $sscanf(line, "%c %h %d", tag, word, count);
				if (n >= 2 && tag == "C") begin
					send_command(word, count);
				end else if (n >= 2 && tag == "E") begin
					check_value(int'(got_q.size() > 0), 1, "samples left for file value");
					check_value(got_q.pop_front(), int'(word), "file sample");
				end
			end
			$fclose(fd);
		end
		// Reset while the triangle streams, so dac_valid is high going in.
		send_command(72'h01, 8);
		wait_responses();
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		mode_now = '0;
		seeds = '{default: 16'h0001};
		rewind_model();
		expect_quiet(20);
		wait_responses();
		if (UUT.u_properties.failures == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			report_failure("Assertions in the properties module failed");
		end
	end

endmodule

`default_nettype wire

//--- dac_gen_input.txt
# C: command word in hex (seed, clear, halt, load_seed, run_random, run_triangle), samples
# E: expected sample in hex, checked in order against the samples just collected
C 01 140
E 0000
E 0400
E 0800
E 0C00
C 08 0
C 01 40
E 0000
E 0400
C 08 0
C 17DDE2468000159C26 80
E ACE1
E 0001
E 1234
E BEEF
C 08 0
C 03 40
E ACE1
E 0001
C 10 0
C 02 40
E 0001
E 0001
C 08 0

//--- dac_gen_top.f
dac_gen_pkg.sv
lfsr_bank.sv
triangle_wave_gen.sv
sample_generator.sv
batch_fifo.sv
dac_serializer.sv
dac_gen_top.sv
dac_gen_properties.sv
dac_gen_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= dac_gen_tb
FILELIST ?= dac_gen_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
